// ==== src/cache_consts.svh ====
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// Address split of the 16-bit CPU byte address
`define CACHE_TAG_W 5
`define CACHE_INDEX_W 8
`define CACHE_OFFSET_W 3

// Cache organization
`define CACHE_SETS 256
`define CACHE_WORDS_PER_LINE 4

// Backing memory
`define MEM_READ_LATENCY 2 // Cycles from read request to data
`define MEM_DEPTH_WORDS 32768

// Statistics counter width
`define STATS_CNT_W 16

`endif

// ==== src/cache_types_pkg.sv ====
`default_nettype none

`include "cache_consts.svh"

package cache_types_pkg;

	// CPU byte address split into cache fields
	typedef struct packed {
		logic [`CACHE_TAG_W-1:0] tag;
		logic [`CACHE_INDEX_W-1:0] index;
		logic [`CACHE_OFFSET_W-1:0] offset;
	} cache_addr_fields_t;

	// Same word seen raw or decoded
	typedef union packed {
		logic [15:0] raw;
		cache_addr_fields_t fields;
	} cache_addr_u;

	// Per-line state of one way
	typedef struct packed {
		logic valid;
		logic dirty;
		logic [`CACHE_TAG_W-1:0] tag;
	} line_meta_t;

	// Single-cycle pulses toward the statistics block
	typedef struct packed {
		logic hit;
		logic miss;
		logic writeback;
	} cache_event_t;

endpackage

`default_nettype wire

// ==== src/mem_bus_pkg.sv ====
`default_nettype none

package mem_bus_pkg;

	// Backing memory request, word addressed
	typedef struct packed {
		logic rd;
		logic wr;
		logic [14:0] addr;
		logic [15:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic valid; // Read data returning
		logic [15:0] data;
	} mem_rsp_t;

	// Wishbone classic, master to slave
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [1:0] adr;
		logic [15:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		logic [15:0] dat;
	} wb_rsp_t;

endpackage

`default_nettype wire

// ==== src/cache_way.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_consts.svh"

module cache_way import cache_types_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic en,
	input logic [7:0] index,
	input logic [2:0] offset,
	input logic comp,
	input logic write,
	input logic [4:0] tag_in,
	input logic [15:0] data_in,
	output line_meta_t meta,
	output logic hit,
	output logic [15:0] data_out
);

	logic [`CACHE_SETS-1:0] valid_q;
	logic [`CACHE_TAG_W-1:0] tag_mem [`CACHE_SETS];
	logic dirty_mem [`CACHE_SETS];
	logic [15:0] data_mem [`CACHE_SETS*`CACHE_WORDS_PER_LINE];

	logic [9:0] word_sel;
	logic tag_match;
	logic fill_wr;
	logic data_wr;

	assign word_sel = {index, offset[2:1]}; // Words sit at even offsets

	assign meta.valid = valid_q[index];
	assign meta.dirty = dirty_mem[index];
	assign meta.tag = tag_mem[index];

	assign tag_match = meta.valid && (meta.tag == tag_in);
	assign hit = en && comp && tag_match;
	assign data_out = data_mem[word_sel];

	// Raw write from the controller, used to fill a line
	assign fill_wr = en && write && !comp;
	assign data_wr = fill_wr || (hit && write);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else if (fill_wr) begin
			valid_q[index] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (data_wr)
			data_mem[word_sel] <= data_in;
		if (fill_wr) begin
			tag_mem[index] <= tag_in;
			dirty_mem[index] <= 1'b0; // Line now matches memory
		end else if (hit && write) begin
			dirty_mem[index] <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== src/lru_table.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_consts.svh"

module lru_table (
	input logic clk,
	input logic rst_n,
	input logic [7:0] index,
	input logic write,
	input logic used_way,
	output logic lru_way
);

	// Each bit names the less recently used way of its set
	logic [`CACHE_SETS-1:0] lru_bits;

	assign lru_way = lru_bits[index];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			lru_bits <= '0;
		else if (write)
			lru_bits[index] <= ~used_way; // Other way becomes the victim
	end

endmodule

`default_nettype wire

// ==== src/backing_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_consts.svh"

module backing_mem import mem_bus_pkg::*; (
	input logic clk,
	input logic rst_n,
	input mem_req_t req,
	output mem_rsp_t rsp
);

	localparam int LAT = `MEM_READ_LATENCY;

	logic [15:0] mem_array [`MEM_DEPTH_WORDS];

	// Delay line, one stage per cycle of read latency
	logic [LAT-1:0] valid_pipe;
	logic [15:0] data_pipe [LAT];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `MEM_DEPTH_WORDS; i++)
				mem_array[i] <= '0;
			valid_pipe <= '0;
		end else begin
			if (req.wr)
				mem_array[req.addr] <= req.wdata; // Visible from the next cycle
			valid_pipe <= {valid_pipe[LAT-2:0], req.rd};
		end
	end

	// Read data follows the valid bits through the stages
	always_ff @(posedge clk) begin
		data_pipe[0] <= mem_array[req.addr];
		for (int i = 1; i < LAT; i++)
			data_pipe[i] <= data_pipe[i-1];
	end

	assign rsp.valid = valid_pipe[LAT-1];
	assign rsp.data = data_pipe[LAT-1];

endmodule

`default_nettype wire

// ==== src/cache_controller.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_controller import cache_types_pkg::*, mem_bus_pkg::*; (
	input logic clk,
	input logic rst_n,
	input cache_addr_u addr,
	input logic [15:0] data_in,
	input logic rd,
	input logic wr,
	output logic [15:0] data_out,
	output logic done,
	output logic stall,
	output logic cache_hit,
	output logic err,
	output logic [1:0] way_en,
	output logic [2:0] way_offset,
	output logic way_comp,
	output logic way_write,
	output logic [4:0] way_tag,
	output logic [15:0] way_wdata,
	input line_meta_t meta0,
	input line_meta_t meta1,
	input logic hit0,
	input logic hit1,
	input logic [15:0] rdata0,
	input logic [15:0] rdata1,
	output logic [7:0] lru_index,
	output logic lru_write,
	output logic lru_used,
	input logic lru_way,
	output mem_req_t mem_req,
	input mem_rsp_t mem_rsp,
	output cache_event_t events
);

	typedef enum logic [3:0] {
		S_IDLE, S_ENABLE,
		S_WB0, S_WB1, S_WB2, S_WB3,
		S_REQ0, S_REQ1, S_REQ2, S_REQ3,
		S_FILL2, S_FILL3, S_DONE
	} state_t;

	state_t state, next_state;

	cache_addr_u req_addr; // Request held during a miss
	logic [15:0] req_data;
	logic req_wr;
	logic victim;
	logic [1:0] fill_cnt;

	logic req, any_hit, fill_phase;
	logic pick_way;
	line_meta_t pick_meta, victim_meta;
	logic [15:0] victim_rdata;
	logic [1:0] victim_oh;
	logic [1:0] wb_word, rq_word;

	assign req = rd | wr;
	assign any_hit = hit0 | hit1;
	assign lru_index = (state == S_IDLE) ? addr.fields.index : req_addr.fields.index;

	// Victim choice: first invalid way, else LRU
	assign pick_way = !meta0.valid ? 1'b0 : !meta1.valid ? 1'b1 : lru_way;
	assign pick_meta = pick_way ? meta1 : meta0;

	assign victim_meta = victim ? meta1 : meta0;
	assign victim_rdata = victim ? rdata1 : rdata0;
	assign victim_oh = victim ? 2'b10 : 2'b01;

	assign wb_word = 2'(state - S_WB0);
	assign rq_word = 2'(state - S_REQ0);
	assign fill_phase = state inside {S_REQ2, S_REQ3, S_FILL2, S_FILL3};

	assign data_out = hit0 ? rdata0 : rdata1;

	always_comb begin
		next_state = state;
		done = 1'b0;
		cache_hit = 1'b0;
		err = 1'b0;
		stall = (state != S_IDLE) && (state != S_DONE);
		way_en = 2'b00;
		way_offset = addr.fields.offset;
		way_comp = 1'b1;
		way_write = 1'b0;
		way_tag = addr.fields.tag;
		way_wdata = data_in;
		lru_write = 1'b0;
		lru_used = 1'b0;
		mem_req = '0;
		events = '0;

		case (state)
			S_IDLE: begin
				way_en = req ? 2'b11 : 2'b00;
				way_write = wr;
				done = req && any_hit;
				cache_hit = done;
				stall = req && !any_hit;
				lru_write = done;
				lru_used = hit1;
				events.hit = done;
				events.miss = stall;
				next_state = stall ? S_ENABLE : S_IDLE;
			end
			S_ENABLE: begin
				next_state = (pick_meta.valid && pick_meta.dirty) ? S_WB0 : S_REQ0;
			end
			S_WB0, S_WB1, S_WB2, S_WB3: begin
				way_en = victim_oh; // Read old line word by word
				way_comp = 1'b0;
				way_offset = {wb_word, 1'b0};
				mem_req.wr = 1'b1;
				mem_req.addr = {victim_meta.tag, req_addr.fields.index, wb_word};
				mem_req.wdata = victim_rdata;
				events.writeback = (state == S_WB0);
				next_state = (state == S_WB3) ? S_REQ0 : state_t'(state + 1'b1);
			end
			S_REQ0, S_REQ1, S_REQ2, S_REQ3: begin
				mem_req.rd = 1'b1;
				mem_req.addr = {req_addr.fields.tag, req_addr.fields.index, rq_word};
				next_state = (state == S_REQ3) ? S_FILL2 : state_t'(state + 1'b1);
			end
			S_FILL2: next_state = S_FILL3;
			S_FILL3: next_state = S_DONE;
			S_DONE: begin
				// Replay the original access against the new line
				way_en = 2'b11;
				way_offset = req_addr.fields.offset;
				way_write = req_wr;
				way_tag = req_addr.fields.tag;
				way_wdata = req_data;
				done = 1'b1;
				lru_write = 1'b1;
				lru_used = victim;
				next_state = S_IDLE;
			end
			default: begin
				err = 1'b1;
				stall = 1'b0;
				next_state = S_IDLE;
			end
		endcase

		if (fill_phase && mem_rsp.valid) begin
			way_en = victim_oh;
			way_comp = 1'b0;
			way_write = 1'b1;
			way_offset = {fill_cnt, 1'b0};
			way_tag = req_addr.fields.tag;
			way_wdata = mem_rsp.data;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
			victim <= 1'b0;
			fill_cnt <= '0;
		end else begin
			state <= next_state;
			if (state == S_ENABLE) begin
				victim <= pick_way;
				fill_cnt <= '0;
			end else if (fill_phase && mem_rsp.valid) begin
				fill_cnt <= fill_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_IDLE && stall) begin
			req_addr <= addr;
			req_data <= data_in;
			req_wr <= wr;
		end
	end

endmodule

`default_nettype wire

// ==== src/cache_stats_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_consts.svh"

module cache_stats_regs import cache_types_pkg::*, mem_bus_pkg::*; (
	input logic clk,
	input logic rst_n,
	input cache_event_t events,
	input wb_req_t wb_in,
	output wb_rsp_t wb_out
);

	logic [`STATS_CNT_W-1:0] cnt [3]; // Hits, misses, write-backs
	logic [2:0] bump;
	logic access;
	logic clear;
	logic [15:0] rd_word;
	logic ack_q;
	logic [15:0] dat_q;

	assign bump = {events.writeback, events.miss, events.hit};

	// New cycle only while no ack is out
	assign access = wb_in.cyc && wb_in.stb && !ack_q;
	assign clear = access && wb_in.we;

	always_comb begin
		rd_word = '0;
		case (wb_in.adr)
			2'd0: rd_word[`STATS_CNT_W-1:0] = cnt[0];
			2'd1: rd_word[`STATS_CNT_W-1:0] = cnt[1];
			2'd2: rd_word[`STATS_CNT_W-1:0] = cnt[2];
			default: rd_word = '0; // Unused slot
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 3; i++)
				cnt[i] <= '0;
			ack_q <= 1'b0;
		end else begin
			for (int i = 0; i < 3; i++) begin
				if (clear && wb_in.adr == 2'(i))
					cnt[i] <= '0; // Clear wins over a pulse
				else if (bump[i] && !(&cnt[i]))
					cnt[i] <= cnt[i] + 1'b1;
			end
			ack_q <= access;
		end
	end

	always_ff @(posedge clk) begin
		if (access)
			dat_q <= rd_word;
	end

	assign wb_out.ack = ack_q;
	assign wb_out.dat = dat_q;

endmodule

`default_nettype wire

// ==== src/mem_system.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_system import cache_types_pkg::*, mem_bus_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic [15:0] addr,
	input logic [15:0] data_in,
	input logic rd,
	input logic wr,
	output logic [15:0] data_out,
	output logic done,
	output logic stall,
	output logic cache_hit,
	output logic err,
	input wb_req_t wb_in,
	output wb_rsp_t wb_out
);

	logic [1:0] way_en;
	logic [2:0] way_offset;
	logic way_comp, way_write;
	logic [4:0] way_tag;
	logic [15:0] way_wdata;
	line_meta_t meta0, meta1;
	logic hit0, hit1;
	logic [15:0] rdata0, rdata1;
	logic [7:0] lru_index; // Also the set index of both ways
	logic lru_write, lru_used, lru_way;
	mem_req_t mem_req;
	mem_rsp_t mem_rsp;
	cache_event_t events;

	cache_controller ctrl_inst (
		.clk, .rst_n, .addr, .data_in, .rd, .wr,
		.data_out, .done, .stall, .cache_hit, .err,
		.way_en, .way_offset, .way_comp, .way_write, .way_tag, .way_wdata,
		.meta0, .meta1, .hit0, .hit1, .rdata0, .rdata1,
		.lru_index, .lru_write, .lru_used, .lru_way,
		.mem_req, .mem_rsp, .events
	);

	cache_way way0_inst (
		.clk, .rst_n, .en(way_en[0]), .index(lru_index), .offset(way_offset),
		.comp(way_comp), .write(way_write), .tag_in(way_tag), .data_in(way_wdata),
		.meta(meta0), .hit(hit0), .data_out(rdata0)
	);

	cache_way way1_inst (
		.clk, .rst_n, .en(way_en[1]), .index(lru_index), .offset(way_offset),
		.comp(way_comp), .write(way_write), .tag_in(way_tag), .data_in(way_wdata),
		.meta(meta1), .hit(hit1), .data_out(rdata1)
	);

	lru_table lru_inst (
		.clk, .rst_n, .index(lru_index), .write(lru_write),
		.used_way(lru_used), .lru_way
	);

	backing_mem mem_inst (.clk, .rst_n, .req(mem_req), .rsp(mem_rsp));

	cache_stats_regs stats_inst (.clk, .rst_n, .events, .wb_in, .wb_out);

endmodule

`default_nettype wire

// ==== test/tb_mem_system.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cache_consts.svh"

module tb_mem_system import cache_types_pkg::*, mem_bus_pkg::*;;

	localparam int NUM_RANDOM = 200;
	localparam int NUM_OPS = 10 + NUM_RANDOM + 10; // Directed, random, Wishbone
	localparam int WATCHDOG_CYCLES = NUM_OPS * (12 + 2) + 100; // Slowest miss plus handoff

	// Expected outcome of one CPU access
	typedef struct packed {
		logic is_read;
		logic [15:0] data;
		logic hit;
		logic writeback;
		logic [3:0] latency;
	} exp_t;

	logic clk;
	logic rst_n;
	logic [15:0] addr;
	logic [15:0] data_in;
	logic [15:0] data_out;
	logic rd, wr, done, stall, cache_hit, err;
	wb_req_t wb_in;
	wb_rsp_t wb_out;

	// Shadow memory and shadow cache state
	logic [15:0] shadow_mem [`MEM_DEPTH_WORDS];
	logic [`CACHE_TAG_W-1:0] shadow_tag [2][`CACHE_SETS];
	logic shadow_valid [2][`CACHE_SETS];
	logic shadow_dirty [2][`CACHE_SETS];
	logic shadow_lru [`CACHE_SETS]; // Less recently used way per set

	exp_t exp_q [$];
	int hit_count, miss_count, wb_count;
	int unsigned cycle_cnt, start_cycle;
	logic busy;

	mem_system mem_system_inst (
		.clk, .rst_n, .addr, .data_in, .rd, .wr,
		.data_out, .done, .stall, .cache_hit, .err, .wb_in, .wb_out
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		if (!rst_n)
			cycle_cnt <= 0;
		else
			cycle_cnt <= cycle_cnt + 1;
	end

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("tests failed");
		$fatal(1, "simulation stopped on the first failure");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
			report_failure($sformatf("error at %0t: %s expected 0x%0h, got 0x%0h",
				$time, name, expected, actual));
	endtask

	function automatic void clear_shadow();
		for (int i = 0; i < `MEM_DEPTH_WORDS; i++)
			shadow_mem[i] = '0;
		for (int s = 0; s < `CACHE_SETS; s++) begin
			shadow_valid[0][s] = 1'b0;
			shadow_valid[1][s] = 1'b0;
			shadow_lru[s] = 1'b0;
		end
	endfunction

	function automatic logic [15:0] make_addr(input logic [4:0] tag, input logic [7:0] index,
		input logic [1:0] word);
		cache_addr_u a;
		a.fields.tag = tag;
		a.fields.index = index;
		a.fields.offset = {word, 1'b0};
		return a.raw;
	endfunction

	// Reference model that updates the shadow state and predicts the access
	function automatic exp_t model_access(input logic is_wr, input logic [15:0] a_raw,
		input logic [15:0] wdata);
		cache_addr_u a;
		exp_t e;
		logic [7:0] set;
		logic w;
		a.raw = a_raw;
		set = a.fields.index;
		e = '0;
		e.is_read = !is_wr;
		w = 1'b0;
		if (shadow_valid[0][set] && shadow_tag[0][set] == a.fields.tag) begin
			e.hit = 1'b1;
		end else if (shadow_valid[1][set] && shadow_tag[1][set] == a.fields.tag) begin
			e.hit = 1'b1;
			w = 1'b1;
		end else begin
			if (!shadow_valid[0][set])
				w = 1'b0;
			else if (!shadow_valid[1][set])
				w = 1'b1;
			else
				w = shadow_lru[set];
			e.writeback = shadow_valid[w][set] && shadow_dirty[w][set];
			e.latency = e.writeback ? 4'd12 : 4'd8;
			shadow_valid[w][set] = 1'b1;
			shadow_tag[w][set] = a.fields.tag;
			shadow_dirty[w][set] = 1'b0;
		end
		if (is_wr) begin
			shadow_dirty[w][set] = 1'b1;
			shadow_mem[a_raw[15:1]] = wdata;
		end
		shadow_lru[set] = ~w;
		e.data = shadow_mem[a_raw[15:1]];
		return e;
	endfunction

	task automatic cpu_access(input logic is_wr, input logic [15:0] a, input logic [15:0] d);
		exp_t e;
		e = model_access(is_wr, a, d);
		hit_count += int'(e.hit);
		miss_count += int'(!e.hit);
		wb_count += int'(e.writeback);
		@(posedge clk);
		exp_q.push_back(e);
		addr <= a;
		data_in <= d;
		rd <= !is_wr;
		wr <= is_wr;
		@(posedge clk);
		rd <= 1'b0; // Request cycle only
		wr <= 1'b0;
		while (exp_q.size() != 0)
			@(posedge clk);
	endtask

	task automatic wb_cycle(input logic we, input logic [1:0] adr, input logic [15:0] wdat,
		output logic [15:0] rdat);
		int waited;
		waited = 0;
		@(posedge clk);
		wb_in <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
		do begin
			@(negedge clk);
			waited++;
		end while (!wb_out.ack && waited < 8);
		check_value("wb_out.ack", 32'd1, 32'(wb_out.ack));
		check_value("wb_out.ack delay", 32'd2, 32'(waited)); // One cycle after cyc and stb
		rdat = wb_out.dat;
		@(posedge clk);
		wb_in <= '0;
		@(negedge clk);
		check_value("wb_out.ack", 32'd0, 32'(wb_out.ack));
	endtask

	// Compares every completed access against the queued prediction
	always @(negedge clk) begin
		exp_t e;
		if (!rst_n) begin
			busy = 1'b0;
		end else begin
			check_value("err", 32'd0, 32'(err));
			if (!busy && (rd || wr)) begin
				busy = 1'b1;
				start_cycle = cycle_cnt;
			end
			if (!done) begin
				check_value("stall", 32'(busy), 32'(stall));
				check_value("cache_hit", 32'd0, 32'(cache_hit));
			end else if (exp_q.size() == 0) begin
				report_failure("done was raised with no access outstanding");
			end else begin
				e = exp_q.pop_front();
				busy = 1'b0;
				check_value("stall", 32'd0, 32'(stall));
				check_value("cache_hit", 32'(e.hit), 32'(cache_hit));
				check_value("done latency", 32'(e.latency), cycle_cnt - start_cycle);
				if (e.is_read)
					check_value("data_out", 32'(e.data), 32'(data_out));
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		report_failure($sformatf("timeout, run did not finish within %0d cycles",
			WATCHDOG_CYCLES));
	end

	initial begin
		logic [15:0] rdat;
		logic [7:0] rand_sets [4];
		logic is_wr;
		logic [1:0] sel;
		logic [1:0] word;
		logic [4:0] tag;
		void'($urandom(32'hff92_24b4));
		clear_shadow();
		hit_count = 0;
		miss_count = 0;
		wb_count = 0;
		rst_n <= 1'b0;
		addr <= '0;
		data_in <= '0;
		rd <= 1'b0;
		wr <= 1'b0;
		wb_in <= '0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_value("done", 32'd0, 32'(done));
		check_value("stall", 32'd0, 32'(stall));
		check_value("cache_hit", 32'd0, 32'(cache_hit));
		check_value("err", 32'd0, 32'(err));
		check_value("wb_out.ack", 32'd0, 32'(wb_out.ack));

		cpu_access(1'b0, 16'h1234, 16'h0000); // Cold miss reads zero
		cpu_access(1'b1, 16'h0a46, 16'hbeef);
		cpu_access(1'b0, 16'h0a46, 16'h0000);

		// Three tags in set 0x5a
		cpu_access(1'b1, make_addr(5'd1, 8'h5a, 2'd1), 16'h1111);
		cpu_access(1'b1, make_addr(5'd2, 8'h5a, 2'd2), 16'h2222);
		cpu_access(1'b0, make_addr(5'd1, 8'h5a, 2'd1), 16'h0000); // Tag 2 becomes LRU
		cpu_access(1'b1, make_addr(5'd3, 8'h5a, 2'd0), 16'h3333); // Dirty eviction
		cpu_access(1'b0, make_addr(5'd2, 8'h5a, 2'd2), 16'h0000);
		cpu_access(1'b0, make_addr(5'd3, 8'h5a, 2'd0), 16'h0000);
		cpu_access(1'b0, make_addr(5'd1, 8'h5a, 2'd1), 16'h0000);

		rand_sets = '{8'h00, 8'h01, 8'h80, 8'hff};
		for (int i = 0; i < NUM_RANDOM; i++) begin
			is_wr = 1'($urandom_range(1, 0));
			tag = 5'($urandom_range(3, 0));
			sel = 2'($urandom_range(3, 0));
			word = 2'($urandom_range(3, 0));
			cpu_access(is_wr, make_addr(tag, rand_sets[sel], word), 16'($urandom));
		end

		wb_cycle(1'b0, 2'd0, 16'h0000, rdat);
		check_value("hit counter", 32'(hit_count), 32'(rdat));
		wb_cycle(1'b0, 2'd1, 16'h0000, rdat);
		check_value("miss counter", 32'(miss_count), 32'(rdat));
		wb_cycle(1'b0, 2'd2, 16'h0000, rdat);
		check_value("writeback counter", 32'(wb_count), 32'(rdat));
		wb_cycle(1'b0, 2'd3, 16'h0000, rdat);
		check_value("register 3", 32'd0, 32'(rdat));
		for (int r = 0; r < 3; r++) begin
			wb_cycle(1'b1, 2'(r), 16'hffff, rdat);
			wb_cycle(1'b0, 2'(r), 16'h0000, rdat);
			check_value("cleared counter", 32'd0, 32'(rdat));
		end

		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+src
src/cache_types_pkg.sv
src/mem_bus_pkg.sv
src/cache_way.sv
src/lru_table.sv
src/backing_mem.sv
src/cache_controller.sv
src/cache_stats_regs.sv
src/mem_system.sv
test/tb_mem_system.sv

// ==== Makefile ====
TOP = tb_mem_system

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): compile.f $(wildcard src/*.sv src/*.svh test/*.sv)
	verilator --binary --timing --timescale 1ns/10ps -j 0 --top-module $(TOP) -f compile.f

lint:
	verilator --lint-only --timing -Wall --timescale 1ns/10ps --top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir
